// File: vga_top.f
source/vga_timing_pkg.sv
source/pixel_pkg.sv
source/vga_scan_if.sv
source/vga_timing.sv
source/pixel_pipeline.sv
source/vga_top.sv
bench/vga_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=vga_top_sim
LOG_FILE=sim.log

verilator --binary --timing \
	-f vga_top.f \
	--top-module vga_top_tb \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" "$LOG_FILE"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see $LOG_FILE"
exit 1

// File: bench/vga_top_tb.sv
module vga_top_tb
	import pixel_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int PIPE_DELAY   = 2; // clocks from the scan position to the pins.

	localparam int H_TOTAL      = 800;
	localparam int V_TOTAL      = 525;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int H_SYNC_LEN   = 96;
	localparam int V_SYNC_LEN   = 2;
	localparam int X_FIRST      = 144;
	localparam int Y_FIRST      = 34;
	localparam int H_VISIBLE    = 640;
	localparam int V_VISIBLE    = 480;

	localparam int NUM_TESTS      = 8;
	localparam int MAX_FRAMES     = NUM_TESTS + 2;
	localparam int MODE_CHANGE_AT = 300 * H_TOTAL + 400; // well inside the visible area.
	localparam int WATCHDOG_TIME  = (NUM_TESTS * FRAME_CYCLES + 50000) * CLK_PERIOD;

	// expected state of the output pins for one scan position.
	typedef struct packed {
		logic        hs;
		logic        vs;
		logic        blank_n;
		logic [23:0] rgb;
	} pins_t;

	logic       clk = 1'b0;
	logic       rst;
	pattern_e   mode;
	logic [7:0] r = 8'h00;
	logic [7:0] g = 8'h00;
	logic [7:0] b = 8'h00;
	logic [9:0] x;
	logic [9:0] y;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic       vga_hs;
	logic       vga_vs;
	logic       vga_blank_n;

	integer      seed;
	int          cycles = 0; // clocks since the end of reset.
	int          err_count = 0;
	pattern_e    frame_mode [MAX_FRAMES];
	logic [31:0] frame_salt [MAX_FRAMES];
	logic [23:0] src_rgb;

	// monitor state.
	pins_t       want;
	logic [23:0] got_rgb;
	int          pin_pos;
	int          pin_frame;
	int          pin_h;
	int          pin_v;
	int          scan_h;
	int          scan_v;
	int          hs_low_cnt = 0;
	int          vs_low_cnt = 0;
	int          shown_cnt = 0;
	int          vs_lines = 0;
	int          shown_lines = 0;

	vga_top u_dut (
		.clk         (clk),
		.rst         (rst),
		.mode        (mode),
		.r           (r),
		.g           (g),
		.b           (b),
		.x           (x),
		.y           (y),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank_n (vga_blank_n)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// the pixel the external source returns, mixed with a per frame salt.
	function automatic logic [23:0] ext_pixel(input logic [9:0] px, input logic [9:0] py,
			input logic [31:0] salt);
		logic [7:0] cr;
		logic [7:0] cg;
		logic [7:0] cb;
		cr = px[7:0] ^ salt[7:0];
		cg = py[7:0] ^ salt[15:8];
		cb = (px[9:2] + py[8:1]) ^ salt[23:16];
		return {cr, cg, cb};
	endfunction

	function automatic logic in_window(input int h, input int v);
		return (h >= X_FIRST) && (h < X_FIRST + H_VISIBLE) &&
			(v >= Y_FIRST) && (v < Y_FIRST + V_VISIBLE);
	endfunction

	// Reference model of the pins for raster position pos, counted from the end of reset.
	function automatic pins_t expected_pins(input int pos, input pattern_e pat,
			input logic [31:0] salt);
		pins_t      res;
		int         h;
		int         v;
		logic [9:0] px;
		logic [9:0] py;
		logic [2:0] bar;
		res.hs      = 1'b1; // outputs still hold their reset values.
		res.vs      = 1'b1;
		res.blank_n = 1'b0;
		res.rgb     = 24'h000000;
		if (pos < 0) begin
			return res;
		end
		h = pos % H_TOTAL;
		v = (pos / H_TOTAL) % V_TOTAL;
		res.hs      = (h >= H_SYNC_LEN);
		res.vs      = (v >= V_SYNC_LEN);
		res.blank_n = in_window(h, v);
		if (!res.blank_n) begin
			return res;
		end
		px = 10'(h - X_FIRST);
		py = 10'(v - Y_FIRST);
		case (pat)
			PAT_EXTERNAL: begin
				res.rgb = ext_pixel(px, py, salt);
			end
			PAT_BARS: begin
				bar     = 3'(px / 10'd80);
				res.rgb = {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
			end
			PAT_GRID: begin
				if ((px % 10'd32) == 10'd0 || (py % 10'd32) == 10'd0) begin
					res.rgb = 24'hffffff;
				end
			end
			PAT_GRADIENT: begin
				res.rgb = {px[9:2], py[8:1], 8'h00};
			end
		endcase
		return res;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp_val);
		if (got !== exp_val) begin
			err_count = err_count + 1;
			$display("FAILED at time %0t: %s is %0h, expected %0h",
				$time, what, got, exp_val);
		end
	endtask

	task automatic wait_for_cycle(input int n);
		do begin
			@(negedge clk);
		end while (cycles < n);
	endtask

	// the pattern of a frame is whatever mode holds at its first position.
	always @(posedge clk) begin
		if (rst) begin
			if (cycles % FRAME_CYCLES == 0) begin
				frame_mode[cycles / FRAME_CYCLES] = mode;
			end
			cycles = cycles + 1;
		end
	end

	// external pixel source, answering from the x and y pins.
	always @(negedge clk) begin
		src_rgb = ext_pixel(x, y, frame_salt[cycles / FRAME_CYCLES]);
		r <= src_rgb[23:16];
		g <= src_rgb[15:8];
		b <= src_rgb[7:0];
	end

	always @(negedge clk) begin
		if (rst) begin
			pin_pos = cycles - PIPE_DELAY;
			if (pin_pos >= 0) begin
				pin_frame = pin_pos / FRAME_CYCLES;
				want = expected_pins(pin_pos, frame_mode[pin_frame], frame_salt[pin_frame]);
			end else begin
				want = expected_pins(pin_pos, PAT_EXTERNAL, 32'h0);
			end
			got_rgb = {vga_r, vga_g, vga_b};
			check_value("vga_hs", 32'(vga_hs), 32'(want.hs));
			check_value("vga_vs", 32'(vga_vs), 32'(want.vs));
			check_value("vga_blank_n", 32'(vga_blank_n), 32'(want.blank_n));
			check_value("colour", 32'(got_rgb), 32'(want.rgb));
			if (!vga_blank_n) begin
				check_value("colour while blanked", 32'(got_rgb), 32'h0);
			end

			// x and y belong to the scan position, two clocks ahead of the pins.
			scan_h = cycles % H_TOTAL;
			scan_v = (cycles / H_TOTAL) % V_TOTAL;
			if (in_window(scan_h, scan_v)) begin
				check_value("x", 32'(x), scan_h - X_FIRST);
				check_value("y", 32'(y), scan_v - Y_FIRST);
			end

			if (pin_pos >= 0) begin
				pin_h = pin_pos % H_TOTAL;
				pin_v = (pin_pos / H_TOTAL) % V_TOTAL;
				if (!vga_hs) begin
					hs_low_cnt = hs_low_cnt + 1;
				end
				if (!vga_vs) begin
					vs_low_cnt = vs_low_cnt + 1;
				end
				if (vga_blank_n) begin
					shown_cnt = shown_cnt + 1;
				end
				if (pin_h == H_TOTAL - 1) begin
					check_value("hsync low clocks in line", hs_low_cnt, H_SYNC_LEN);
					if (shown_cnt == H_VISIBLE) begin
						shown_lines = shown_lines + 1;
					end else begin
						check_value("visible clocks in line", shown_cnt, 0);
					end
					if (vs_low_cnt == H_TOTAL) begin
						vs_lines = vs_lines + 1; // a whole line inside the vsync pulse.
					end else begin
						check_value("vsync low clocks in line", vs_low_cnt, 0);
					end
					hs_low_cnt = 0;
					vs_low_cnt = 0;
					shown_cnt  = 0;
					if (pin_v == V_TOTAL - 1) begin
						check_value("vsync low lines in frame", vs_lines, V_SYNC_LEN);
						check_value("visible lines in frame", shown_lines, V_VISIBLE);
						vs_lines    = 0;
						shown_lines = 0;
					end
				end
			end
		end
	end

	initial begin
		string    test_name [NUM_TESTS];
		pattern_e test_mode [NUM_TESTS];
		int       t;
		int       errs_before;
		int       test_errs;
		int       passed;
		rst  = 1'b0;
		mode = PAT_EXTERNAL;
		seed = 32'h7c501683;
		for (int i = 0; i < MAX_FRAMES; i++) begin
			frame_salt[i] = $random(seed);
		end
		test_name[0] = "sync timing after reset";
		test_name[1] = "blanking";
		test_name[2] = "external source";
		test_name[3] = "colour bars";
		test_name[4] = "grid";
		test_name[5] = "gradient";
		test_name[6] = "mode change in mid frame";
		test_name[7] = "grid after the mode latch";
		test_mode[0] = PAT_EXTERNAL;
		test_mode[1] = PAT_EXTERNAL;
		test_mode[2] = PAT_EXTERNAL;
		test_mode[3] = PAT_BARS;
		test_mode[4] = PAT_GRID;
		test_mode[5] = PAT_GRADIENT;
		test_mode[6] = PAT_BARS;
		test_mode[7] = PAT_GRID; // lands in the middle of the bars frame.
		passed = 0;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst <= 1'b1;

		for (t = 0; t < NUM_TESTS; t++) begin
			errs_before = err_count;
			// the mode for the next frame is set while this one is scanned.
			if (t + 1 < NUM_TESTS) begin
				wait_for_cycle(t * FRAME_CYCLES + MODE_CHANGE_AT);
				mode <= test_mode[t + 1];
			end
			wait_for_cycle((t + 1) * FRAME_CYCLES + PIPE_DELAY - 1);
			@(posedge clk);
			test_errs = err_count - errs_before;
			if (test_errs == 0) begin
				passed = passed + 1;
				$display("test %0d, %s: passed", t, test_name[t]);
			end else begin
				$display("test %0d, %s: %0d mismatches", t, test_name[t], test_errs);
			end
		end

		$display("%0d tests run, %0d passed, %0d failed, %0d mismatches in all",
			NUM_TESTS, passed, NUM_TESTS - passed, err_count);
		if (err_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: the frames did not complete in the expected time.");
		$display("Something failed");
		$finish;
	end

endmodule

// File: source/vga_top.sv
module vga_top
	import vga_timing_pkg::*;
	import pixel_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [1:0]           mode,
	input  logic [7:0]           r,
	input  logic [7:0]           g,
	input  logic [7:0]           b,
	output logic [H_COUNT_W-1:0] x,
	output logic [V_COUNT_W-1:0] y,
	output logic [7:0]           vga_r,
	output logic [7:0]           vga_g,
	output logic [7:0]           vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 vga_blank_n
);

	color_t ext_color;
	color_t pix_color;

	vga_scan_if scan_bus ();

	vga_timing u_timing (
		.clk  (clk),
		.rst  (rst),
		.scan (scan_bus)
	);

	// the external source answers from x and y within the same clock.
	assign x = scan_bus.x;
	assign y = scan_bus.y;
	assign ext_color = '{r: r, g: g, b: b};

	pixel_pipeline u_pipeline (
		.clk       (clk),
		.rst       (rst),
		.scan      (scan_bus),
		.mode      (pattern_e'(mode)),
		.ext_color (ext_color),
		.color     (pix_color),
		.hsync     (vga_hs),
		.vsync     (vga_vs),
		.blank_n   (vga_blank_n)
	);

	assign vga_r = pix_color.r;
	assign vga_g = pix_color.g;
	assign vga_b = pix_color.b;

endmodule

// File: source/pixel_pipeline.sv
module pixel_pipeline
	import vga_timing_pkg::*;
	import pixel_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	vga_scan_if.sink   scan,
	input  pattern_e   mode,
	input  color_t     ext_color,
	output color_t     color,
	output logic       hsync,
	output logic       vsync,
	output logic       blank_n
);

	pattern_e frame_pat; // pattern of the frame being scanned.
	pattern_e cur_pat;
	color_t   gen_color;
	logic [2:0] bar;
	logic       on_grid;

	// stage 1 registers.
	color_t s1_color;
	logic   s1_hs;
	logic   s1_vs;
	logic   s1_active;

	// mode is sampled at the first position of each frame only.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			frame_pat <= PAT_EXTERNAL;
		end else if (scan.frame_start) begin
			frame_pat <= mode;
		end
	end

	// the first position of a frame already belongs to the new pattern.
	assign cur_pat = scan.frame_start ? mode : frame_pat;

	assign bar     = 3'(scan.x / BAR_WIDTH);
	assign on_grid = ((scan.x % GRID_SPACING) == '0) || ((scan.y % GRID_SPACING) == '0);

	always_comb begin
		case (cur_pat)
			PAT_EXTERNAL: begin
				gen_color = ext_color;
			end
			PAT_BARS: begin
				// each bar index bit switches one primary fully on.
				gen_color.r = {8{bar[2]}};
				gen_color.g = {8{bar[1]}};
				gen_color.b = {8{bar[0]}};
			end
			PAT_GRID: begin
				gen_color = on_grid ? WHITE : BLACK;
			end
			PAT_GRADIENT: begin
				gen_color.r = scan.x[H_COUNT_W-1 -: 8];
				gen_color.g = scan.y[8:1]; // y never reaches 512, so bit 9 is dropped.
				gen_color.b = 8'h00;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		s1_color <= gen_color;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			s1_hs     <= 1'b1;
			s1_vs     <= 1'b1;
			s1_active <= 1'b0;
		end else begin
			s1_hs     <= scan.hs;
			s1_vs     <= scan.vs;
			s1_active <= scan.active;
		end
	end

	// Stage 2 blanks the colour outside the window and drives the pins.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			color   <= BLACK;
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			blank_n <= 1'b0;
		end else begin
			color   <= s1_active ? s1_color : BLACK;
			hsync   <= s1_hs;
			vsync   <= s1_vs;
			blank_n <= s1_active;
		end
	end

endmodule

// File: source/vga_timing.sv
module vga_timing
	import vga_timing_pkg::*;
(
	input logic         clk,
	input logic         rst,
	vga_scan_if.source  scan
);

	logic [H_COUNT_W-1:0] h_cnt;
	logic [V_COUNT_W-1:0] v_cnt;
	logic [H_COUNT_W-1:0] h_next;
	logic [V_COUNT_W-1:0] v_next;
	logic                 h_wrap;
	logic                 v_wrap;
	logic                 h_active_next;
	logic                 v_active_next;

	assign h_wrap = (h_cnt == H_TOTAL - 1'b1);
	assign v_wrap = (v_cnt == V_TOTAL - 1'b1);

	// the vertical count only moves on the last clock of a line.
	always_comb begin
		h_next = h_wrap ? '0 : h_cnt + 1'b1;
		v_next = v_cnt;
		if (h_wrap) begin
			v_next = v_wrap ? '0 : v_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
		end
	end

	// The scan outputs are decoded from the next count, so that once
	// registered they line up with the counter value of the same cycle.
	assign h_active_next = (h_next >= X_START) && (h_next < X_START + H_ACTIVE);
	assign v_active_next = (v_next >= Y_START) && (v_next < Y_START + V_ACTIVE);

	// reset values describe position 0,0, which is where the counters start.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			scan.hs          <= 1'b0;
			scan.vs          <= 1'b0;
			scan.active      <= 1'b0;
			scan.frame_start <= 1'b1;
		end else begin
			scan.hs          <= (h_next >= H_SYNC);
			scan.vs          <= (v_next >= V_SYNC);
			scan.active      <= h_active_next && v_active_next;
			scan.frame_start <= (h_next == '0) && (v_next == '0);
		end
	end

	// Coordinates follow the window and keep their last value in the blanking.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			scan.x <= '0;
			scan.y <= '0;
		end else if (h_active_next && v_active_next) begin
			scan.x <= h_next - X_START;
			scan.y <= v_next - Y_START;
		end
	end

endmodule

// File: source/vga_scan_if.sv
interface vga_scan_if
	import vga_timing_pkg::*;
();

	logic hs;          // low during the horizontal sync pulse.
	logic vs;          // low during the vertical sync pulse.
	logic active;      // position is inside the visible window.
	logic frame_start; // one clock at scan position 0,0.

	// position inside the visible window, only meaningful while active is high.
	logic [H_COUNT_W-1:0] x;
	logic [V_COUNT_W-1:0] y;

	modport source (
		output hs,
		output vs,
		output active,
		output frame_start,
		output x,
		output y
	);

	modport sink (
		input hs,
		input vs,
		input active,
		input frame_start,
		input x,
		input y
	);

endinterface

// File: source/pixel_pkg.sv
package pixel_pkg;

	// one pixel as it goes to the DAC.
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} color_t;

	// what the pixel pipeline shows, chosen once per frame.
	typedef enum logic [1:0] {
		PAT_EXTERNAL = 2'd0, // pixel comes from outside the design.
		PAT_BARS     = 2'd1,
		PAT_GRID     = 2'd2,
		PAT_GRADIENT = 2'd3
	} pattern_e;

	// eight bars over the 640 visible pixels.
	localparam logic [9:0] BAR_WIDTH = 10'd80;

	// grid lines sit on every multiple of this, in both directions.
	localparam logic [9:0] GRID_SPACING = 10'd32;

	localparam color_t BLACK = '0;
	localparam color_t WHITE = '1;

endpackage

// File: source/vga_timing_pkg.sv
package vga_timing_pkg;

	// both counters fit in ten bits, up to 1023.
	localparam int H_COUNT_W = 10;
	localparam int V_COUNT_W = 10;

	// horizontal timing in pixel clocks.
	// the line starts with the sync pulse, then the back porch.
	localparam logic [H_COUNT_W-1:0] H_SYNC   = 10'd96;
	localparam logic [H_COUNT_W-1:0] H_BACK   = 10'd48;
	localparam logic [H_COUNT_W-1:0] H_ACTIVE = 10'd640;
	localparam logic [H_COUNT_W-1:0] H_FRONT  = 10'd16;
	localparam logic [H_COUNT_W-1:0] H_TOTAL  =
		H_SYNC + H_BACK + H_ACTIVE + H_FRONT; // 800 clocks per line.

	// vertical timing in lines, in the same order as a line.
	localparam logic [V_COUNT_W-1:0] V_SYNC   = 10'd2;
	localparam logic [V_COUNT_W-1:0] V_BACK   = 10'd32;
	localparam logic [V_COUNT_W-1:0] V_ACTIVE = 10'd480;
	localparam logic [V_COUNT_W-1:0] V_FRONT  = 10'd11;
	localparam logic [V_COUNT_W-1:0] V_TOTAL  =
		V_SYNC + V_BACK + V_ACTIVE + V_FRONT; // 525 lines per frame.

	// first counter values inside the visible window.
	localparam logic [H_COUNT_W-1:0] X_START = H_SYNC + H_BACK;
	localparam logic [V_COUNT_W-1:0] Y_START = V_SYNC + V_BACK;

endpackage
